// ==== design/blimp_cfg.svh ====
// --------------------
// Blimp core configuration
// Reset PC, tag width and multiplier depth
// --------------------

`ifndef BLIMP_CFG_SVH
`define BLIMP_CFG_SVH

// First fetch address
`define BLIMP_RESET_PC 32'h0000_0200

// Width of the issue order tag
`define BLIMP_SEQ_BITS 5

// Number of multiplier pipe stages
`define BLIMP_MUL_STAGES 3

`endif

// ==== design/blimp_pkg.sv ====
// --------------------
// Blimp core types
// Shared words, indices, tags and operations
// --------------------

`include "blimp_cfg.svh"

package blimp_pkg;

  // --------------------
  // Data and address widths
  // --------------------

  // Data and instruction word
  typedef logic [31:0] word_t;

  // Program counter
  typedef logic [31:0] addr_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // Issue order tag, wraps freely
  typedef logic [`BLIMP_SEQ_BITS-1:0] seq_num_t;

  // --------------------
  // Operations
  // --------------------

  // ADDI uses OP_ADD with the immediate as operand b
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_MUL
  } op_t;

endpackage

// ==== design/blimp_intf.sv ====
// --------------------
// Blimp stage interfaces
// Valid/ready links between the pipeline stages
// --------------------

`timescale 1ns/1ps

// Fetch to decode
interface f_d_intf;
  logic                val;
  logic                rdy;
  blimp_pkg::word_t    inst;
  blimp_pkg::addr_t    pc;

  modport fetch  (output val, inst, pc, input rdy);
  modport decode (input val, inst, pc, output rdy);
endinterface

// Decode to one execute pipe
interface d_x_intf;
  logic                val;
  logic                rdy;
  blimp_pkg::op_t      op;
  blimp_pkg::word_t    op_a;
  blimp_pkg::word_t    op_b;
  blimp_pkg::reg_idx_t waddr;
  logic                wen;
  blimp_pkg::addr_t    pc;
  blimp_pkg::seq_num_t seq_num;

  modport issue (output val, op, op_a, op_b, waddr, wen, pc, seq_num, input rdy);
  modport exec  (input val, op, op_a, op_b, waddr, wen, pc, seq_num, output rdy);
endinterface

// One execute pipe to writeback
interface x_w_intf;
  logic                val;
  logic                rdy;
  blimp_pkg::word_t    wdata;
  blimp_pkg::reg_idx_t waddr;
  logic                wen;
  blimp_pkg::addr_t    pc;
  blimp_pkg::seq_num_t seq_num;

  modport exec (output val, wdata, waddr, wen, pc, seq_num, input rdy);
  modport wb   (input val, wdata, waddr, wen, pc, seq_num, output rdy);
endinterface

// ==== design/fetch_unit.sv ====
// --------------------
// Fetch unit
// One request in flight, holds each word until decode takes it
// --------------------

`timescale 1ns/1ps

`include "blimp_cfg.svh"

module fetch_unit (
  input  logic             clk,
  input  logic             arst_n,
  output logic             imem_req_val,
  output blimp_pkg::addr_t imem_req_addr,
  input  logic             imem_req_rdy,
  input  logic             imem_resp_val,
  input  blimp_pkg::word_t imem_resp_data,
  f_d_intf.fetch           f
);

  typedef enum logic [1:0] {REQ, WAIT, HOLD} state_t;

  state_t           state_q;
  blimp_pkg::addr_t pc_q;
  blimp_pkg::word_t inst_q;
  logic             req_val_q;

  // Request is a flop, so it stays low for a cycle after reset
  assign imem_req_val  = req_val_q;
  assign imem_req_addr = pc_q;

  // Held instruction toward decode
  assign f.val  = (state_q == HOLD);
  assign f.inst = inst_q;
  assign f.pc   = pc_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= REQ;
      req_val_q <= 1'b0;
      pc_q      <= `BLIMP_RESET_PC;
    end else begin
      case (state_q)
        REQ: begin
          if (!req_val_q) begin
            // Raise request on the first cycle out of reset
            req_val_q <= 1'b1;
          end else if (imem_req_rdy) begin
            req_val_q <= 1'b0;
            state_q   <= WAIT;
          end
        end
        WAIT: begin
          if (imem_resp_val) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          // Handoff to decode, then next sequential PC
          if (f.rdy) begin
            pc_q      <= pc_q + 32'd4;
            req_val_q <= 1'b1;
            state_q   <= REQ;
          end
        end
        default: state_q <= REQ;
      endcase
    end
  end

  // Response capture
  always_ff @(posedge clk) begin
    if (state_q == WAIT && imem_resp_val) begin
      inst_q <= imem_resp_data;
    end
  end

endmodule

// ==== design/decode_issue_unit.sv ====
// --------------------
// Decode and issue unit
// Register file, scoreboard and steering to ALU or multiplier
// --------------------

`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                clk,
  input  logic                arst_n,
  f_d_intf.decode             f,
  d_x_intf.issue              alu,
  d_x_intf.issue              mul,
  input  logic                rf_wen,
  input  blimp_pkg::reg_idx_t rf_waddr,
  input  blimp_pkg::word_t    rf_wdata,
  input  logic                complete_val,
  input  blimp_pkg::reg_idx_t complete_waddr
);

  blimp_pkg::word_t    regs [32];
  logic [31:0]         pending_q;
  logic [31:0]         busy;
  blimp_pkg::seq_num_t seq_q;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  blimp_pkg::reg_idx_t rs1;
  blimp_pkg::reg_idx_t rs2;
  blimp_pkg::reg_idx_t rd;
  blimp_pkg::word_t    imm;
  blimp_pkg::word_t    rs1_data;
  blimp_pkg::word_t    rs2_data;
  blimp_pkg::op_t      op;
  logic                use_rs2;
  logic                dec_wen;
  logic                wen;
  logic                is_mul;
  logic                hazard;
  logic                issue;

  // --------------------
  // Field extraction
  // --------------------
  assign opcode = f.inst[6:0];
  assign rd     = f.inst[11:7];
  assign funct3 = f.inst[14:12];
  assign rs1    = f.inst[19:15];
  assign rs2    = f.inst[24:20];
  assign funct7 = f.inst[31:25];
  // Sign-extended I-type immediate
  assign imm    = {{20{f.inst[31]}}, f.inst[31:20]};

  // Opcode decode, anything unknown becomes a NOP
  always_comb begin
    op      = blimp_pkg::OP_ADD;
    use_rs2 = 1'b0;
    dec_wen = 1'b0;
    case (opcode)
      7'b0110011: begin
        use_rs2 = 1'b1;
        dec_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: op = blimp_pkg::OP_ADD;
          {7'b0100000, 3'b000}: op = blimp_pkg::OP_SUB;
          {7'b0000000, 3'b111}: op = blimp_pkg::OP_AND;
          {7'b0000000, 3'b110}: op = blimp_pkg::OP_OR;
          {7'b0000000, 3'b100}: op = blimp_pkg::OP_XOR;
          {7'b0000001, 3'b000}: op = blimp_pkg::OP_MUL;
          default: begin
            use_rs2 = 1'b0;
            dec_wen = 1'b0;
          end
        endcase
      end
      // ADDI
      7'b0010011: dec_wen = (funct3 == 3'b000);
      default: dec_wen = 1'b0;
    endcase
  end

  // No write and no scoreboard bit for x0
  assign wen    = dec_wen && (rd != '0);
  assign is_mul = (op == blimp_pkg::OP_MUL);

  // --------------------
  // Register read with writeback bypass
  // --------------------
  assign rs1_data = (rf_wen && rf_waddr == rs1 && rs1 != '0) ? rf_wdata : regs[rs1];
  assign rs2_data = (rf_wen && rf_waddr == rs2 && rs2 != '0) ? rf_wdata : regs[rs2];

  // --------------------
  // Hazard check
  // --------------------
  // Same-cycle completion already counts as cleared
  assign busy   = pending_q & ~(complete_val ? (32'd1 << complete_waddr) : 32'd0);
  assign hazard = busy[rs1] || (use_rs2 && busy[rs2]) || (wen && busy[rd]);

  assign f.rdy = !hazard && (is_mul ? mul.rdy : alu.rdy);
  assign issue = f.val && f.rdy;

  // Valid toward the chosen pipe only
  assign alu.val = f.val && !hazard && !is_mul;
  assign mul.val = f.val && !hazard && is_mul;

  // Same payload to both pipes
  assign alu.op      = op;
  assign alu.op_a    = rs1_data;
  assign alu.op_b    = use_rs2 ? rs2_data : imm;
  assign alu.waddr   = rd;
  assign alu.wen     = wen;
  assign alu.pc      = f.pc;
  assign alu.seq_num = seq_q;
  assign mul.op      = op;
  assign mul.op_a    = rs1_data;
  assign mul.op_b    = rs2_data;
  assign mul.waddr   = rd;
  assign mul.wen     = wen;
  assign mul.pc      = f.pc;
  assign mul.seq_num = seq_q;

  // --------------------
  // State
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending_q <= '0;
      seq_q     <= '0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Set on issue, clear on completion
      pending_q <= busy | ((issue && wen) ? (32'd1 << rd) : 32'd0);
      if (issue) begin
        seq_q <= seq_q + blimp_pkg::seq_num_t'(1);
      end
      if (rf_wen && rf_waddr != '0) begin
        regs[rf_waddr] <= rf_wdata;
      end
    end
  end

endmodule

// ==== design/alu_unit.sv ====
// --------------------
// ALU pipe
// Single-cycle integer ops into an output register
// --------------------

`timescale 1ns/1ps

module alu_unit (
  input logic    clk,
  input logic    arst_n,
  d_x_intf.exec  d,
  x_w_intf.exec  w
);

  logic             val_q;
  blimp_pkg::word_t result;

  // Free slot or draining this cycle
  assign d.rdy = !val_q || w.rdy;

  always_comb begin
    case (d.op)
      blimp_pkg::OP_SUB: result = d.op_a - d.op_b;
      blimp_pkg::OP_AND: result = d.op_a & d.op_b;
      blimp_pkg::OP_OR:  result = d.op_a | d.op_b;
      blimp_pkg::OP_XOR: result = d.op_a ^ d.op_b;
      default:           result = d.op_a + d.op_b;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      val_q <= 1'b0;
    end else if (d.rdy) begin
      val_q <= d.val;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (d.val && d.rdy) begin
      w.wdata   <= result;
      w.waddr   <= d.waddr;
      w.wen     <= d.wen;
      w.pc      <= d.pc;
      w.seq_num <= d.seq_num;
    end
  end

  assign w.val = val_q;

endmodule

// ==== design/multiplier_unit.sv ====
// --------------------
// Multiplier pipe
// Pipelined 32x32 low-word product, freezes on back-pressure
// --------------------

`timescale 1ns/1ps

`include "blimp_cfg.svh"

module multiplier_unit (
  input logic    clk,
  input logic    arst_n,
  d_x_intf.exec  d,
  x_w_intf.exec  w
);

  localparam int unsigned STAGES = `BLIMP_MUL_STAGES;
  localparam int unsigned LAST   = STAGES - 1;

  // Per-stage valid and metadata
  logic                val_q   [STAGES];
  blimp_pkg::reg_idx_t waddr_q [STAGES];
  logic                wen_q   [STAGES];
  blimp_pkg::addr_t    pc_q    [STAGES];
  blimp_pkg::seq_num_t seq_q   [STAGES];

  // Datapath per stage
  blimp_pkg::word_t    a_q;
  blimp_pkg::word_t    b_q;
  blimp_pkg::word_t    pp_lo_q;
  logic [15:0]         pp_hi_q;
  blimp_pkg::word_t    prod_q;
  blimp_pkg::word_t    pp_lo_full;
  logic [15:0]         pp_hi_full;
  logic                stall;

  // Whole pipe waits on an unaccepted result
  assign stall = val_q[LAST] && !w.rdy;
  assign d.rdy = !stall;

  // Only the bits that reach the low word
  assign pp_lo_full = a_q * {16'd0, b_q[15:0]};
  assign pp_hi_full = a_q[15:0] * b_q[31:16];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < STAGES; i++) begin
        val_q[i] <= 1'b0;
      end
    end else if (!stall) begin
      val_q[0] <= d.val;
      for (int i = 1; i < STAGES; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      // Stage 0 operands
      a_q        <= d.op_a;
      b_q        <= d.op_b;
      waddr_q[0] <= d.waddr;
      wen_q[0]   <= d.wen;
      pc_q[0]    <= d.pc;
      seq_q[0]   <= d.seq_num;
      // Stage 1 partial products
      pp_lo_q    <= pp_lo_full;
      pp_hi_q    <= pp_hi_full;
      // Stage 2 sum
      prod_q     <= pp_lo_q + {pp_hi_q, 16'd0};
      for (int i = 1; i < STAGES; i++) begin
        waddr_q[i] <= waddr_q[i-1];
        wen_q[i]   <= wen_q[i-1];
        pc_q[i]    <= pc_q[i-1];
        seq_q[i]   <= seq_q[i-1];
      end
    end
  end

  assign w.val     = val_q[LAST];
  assign w.wdata   = prod_q;
  assign w.waddr   = waddr_q[LAST];
  assign w.wen     = wen_q[LAST];
  assign w.pc      = pc_q[LAST];
  assign w.seq_num = seq_q[LAST];

endmodule

// ==== design/writeback_commit_unit.sv ====
// --------------------
// Writeback and commit unit
// Picks one result per cycle, writes back, traces
// --------------------

`timescale 1ns/1ps

module writeback_commit_unit (
  input  logic                clk,
  input  logic                arst_n,
  x_w_intf.wb                 alu,
  x_w_intf.wb                 mul,
  output logic                rf_wen,
  output blimp_pkg::reg_idx_t rf_waddr,
  output blimp_pkg::word_t    rf_wdata,
  output logic                complete_val,
  output blimp_pkg::reg_idx_t complete_waddr,
  output logic                trace_val,
  output blimp_pkg::addr_t    trace_pc,
  output blimp_pkg::reg_idx_t trace_waddr,
  output blimp_pkg::word_t    trace_wdata,
  output logic                trace_wen,
  output blimp_pkg::seq_num_t trace_seq_num
);

  logic sel_val;
  logic sel_wen;

  // Multiplier always wins, ALU holds when it loses
  assign mul.rdy = 1'b1;
  assign alu.rdy = !mul.val;
  assign sel_val = mul.val || alu.val;
  assign sel_wen = mul.val ? mul.wen : alu.wen;

  // Register write and scoreboard clear in the accept cycle
  assign rf_wen         = sel_val && sel_wen;
  assign rf_waddr       = mul.val ? mul.waddr : alu.waddr;
  assign rf_wdata       = mul.val ? mul.wdata : alu.wdata;
  assign complete_val   = rf_wen;
  assign complete_waddr = rf_waddr;

  // --------------------
  // Trace record
  // --------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trace_val <= 1'b0;
    end else begin
      trace_val <= sel_val;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_val) begin
      trace_pc      <= mul.val ? mul.pc : alu.pc;
      trace_waddr   <= rf_waddr;
      trace_wdata   <= rf_wdata;
      trace_wen     <= sel_wen;
      trace_seq_num <= mul.val ? mul.seq_num : alu.seq_num;
    end
  end

endmodule

// ==== design/blimp_core.sv ====
// --------------------
// Blimp core top level
// Fetch, decode-issue, ALU, multiplier and writeback
// --------------------

`timescale 1ns/1ps

module blimp_core (
  input  logic                clk,
  input  logic                arst_n,
  // Instruction memory
  output logic                imem_req_val,
  output blimp_pkg::addr_t    imem_req_addr,
  input  logic                imem_req_rdy,
  input  logic                imem_resp_val,
  input  blimp_pkg::word_t    imem_resp_data,
  // Commit trace
  output logic                trace_val,
  output blimp_pkg::addr_t    trace_pc,
  output blimp_pkg::reg_idx_t trace_waddr,
  output blimp_pkg::word_t    trace_wdata,
  output logic                trace_wen,
  output blimp_pkg::seq_num_t trace_seq_num
);

  // --------------------
  // Stage links
  // --------------------
  f_d_intf f_d ();
  d_x_intf alu_d_x ();
  d_x_intf mul_d_x ();
  x_w_intf alu_x_w ();
  x_w_intf mul_x_w ();

  // Writeback back to decode
  logic                rf_wen;
  blimp_pkg::reg_idx_t rf_waddr;
  blimp_pkg::word_t    rf_wdata;
  logic                complete_val;
  blimp_pkg::reg_idx_t complete_waddr;

  // --------------------
  // Units
  // --------------------
  fetch_unit u_fetch_unit (
    .clk, .arst_n,
    .imem_req_val, .imem_req_addr, .imem_req_rdy,
    .imem_resp_val, .imem_resp_data,
    .f (f_d)
  );

  decode_issue_unit u_decode_issue_unit (
    .clk, .arst_n,
    .f   (f_d),
    .alu (alu_d_x),
    .mul (mul_d_x),
    .rf_wen, .rf_waddr, .rf_wdata,
    .complete_val, .complete_waddr
  );

  alu_unit u_alu_unit (.clk, .arst_n, .d (alu_d_x), .w (alu_x_w));

  multiplier_unit u_multiplier_unit (.clk, .arst_n, .d (mul_d_x), .w (mul_x_w));

  writeback_commit_unit u_writeback_commit_unit (
    .clk, .arst_n,
    .alu (alu_x_w),
    .mul (mul_x_w),
    .rf_wen, .rf_waddr, .rf_wdata,
    .complete_val, .complete_waddr,
    .trace_val, .trace_pc, .trace_waddr,
    .trace_wdata, .trace_wen, .trace_seq_num
  );

endmodule

// ==== bench/blimp_core_tb.sv ====
// --------------------
// Blimp core testbench
// Random RV32 program from a ROM with jittered responses,
// sequential golden model, trace checks and closing report
// --------------------

`timescale 1ns/1ps

`include "blimp_cfg.svh"

module blimp_core_tb;

  localparam int PROG_LEN        = 64;
  localparam int ROM_DEPTH       = 128;
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 8;
  localparam int DRAIN_CYCLES    = 20;
  localparam int WATCHDOG_CYCLES = PROG_LEN * 20;

  logic                clk;
  logic                arst_n;
  logic                imem_req_val;
  blimp_pkg::addr_t    imem_req_addr;
  logic                imem_req_rdy;
  logic                imem_resp_val;
  blimp_pkg::word_t    imem_resp_data;
  logic                trace_val;
  blimp_pkg::addr_t    trace_pc;
  blimp_pkg::reg_idx_t trace_waddr;
  blimp_pkg::word_t    trace_wdata;
  logic                trace_wen;
  blimp_pkg::seq_num_t trace_seq_num;

  int seed = 94330;

  // ROM image and expected results per program slot
  blimp_pkg::word_t    rom        [ROM_DEPTH];
  blimp_pkg::word_t    exp_wdata  [PROG_LEN];
  blimp_pkg::reg_idx_t exp_waddr  [PROG_LEN];
  logic                exp_is_mul [PROG_LEN];
  int                  traced     [PROG_LEN];

  int               traced_total = 0;
  int               mismatches   = 0;
  int               failures     = 0;
  int               alu_checked  = 0;
  int               mul_checked  = 0;
  blimp_pkg::addr_t exp_req_addr = `BLIMP_RESET_PC;

  blimp_core u_blimp_core (
    .clk, .arst_n,
    .imem_req_val, .imem_req_addr, .imem_req_rdy,
    .imem_resp_val, .imem_resp_data,
    .trace_val, .trace_pc, .trace_waddr,
    .trace_wdata, .trace_wen, .trace_seq_num
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // Program and golden model
  // --------------------

  // ADDI x0 filler with an immediate folded from the address
  function automatic blimp_pkg::word_t filler_word(blimp_pkg::addr_t a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'd0, a[31:26]};
    return {imm, 5'd0, 3'b000, 5'd0, 7'b0010011};
  endfunction

  function automatic blimp_pkg::word_t rom_word(blimp_pkg::addr_t a);
    int unsigned idx;
    if (a < `BLIMP_RESET_PC) begin
      return filler_word(a);
    end
    idx = (a - `BLIMP_RESET_PC) >> 2;
    if (idx < ROM_DEPTH) begin
      return rom[idx];
    end
    return filler_word(a);
  endfunction

  // Kinds 0..6: ADD SUB AND OR XOR ADDI MUL, registers x0..x7
  task automatic build_program();
    blimp_pkg::word_t gold [8];
    blimp_pkg::word_t a;
    blimp_pkg::word_t b;
    blimp_pkg::word_t res;
    int               kind;
    logic [2:0]       rd;
    logic [2:0]       rs1;
    logic [2:0]       rs2;
    logic [11:0]      imm;
    logic [6:0]       funct7;
    logic [2:0]       funct3;
    for (int r = 0; r < 8; r++) begin
      gold[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      kind   = {$random(seed)} % 7;
      rd     = 3'($random(seed));
      rs1    = 3'($random(seed));
      rs2    = 3'($random(seed));
      imm    = 12'($random(seed));
      funct7 = 7'b0000000;
      funct3 = 3'b000;
      a      = gold[rs1];
      b      = (kind == 5) ? {{20{imm[11]}}, imm} : gold[rs2];
      case (kind)
        0: res = a + b;
        1: begin
          res    = a - b;
          funct7 = 7'b0100000;
        end
        2: begin
          res    = a & b;
          funct3 = 3'b111;
        end
        3: begin
          res    = a | b;
          funct3 = 3'b110;
        end
        4: begin
          res    = a ^ b;
          funct3 = 3'b100;
        end
        5: res = a + b;
        default: begin
          // Low word of the product
          res    = a * b;
          funct7 = 7'b0000001;
        end
      endcase
      if (kind == 5) begin
        rom[i] = {imm, 2'b00, rs1, 3'b000, 2'b00, rd, 7'b0010011};
      end else begin
        rom[i] = {funct7, 2'b00, rs2, 2'b00, rs1, funct3, 2'b00, rd, 7'b0110011};
      end
      exp_wdata[i]  = res;
      exp_waddr[i]  = {2'b00, rd};
      exp_is_mul[i] = (kind == 6);
      traced[i]     = 0;
      // x0 stays zero
      if (rd != 3'd0) begin
        gold[rd] = res;
      end
    end
    for (int i = PROG_LEN; i < ROM_DEPTH; i++) begin
      rom[i] = filler_word(`BLIMP_RESET_PC + 32'(i * 4));
    end
  endtask

  // --------------------
  // Instruction memory model
  // --------------------
  initial begin
    logic             fire;
    blimp_pkg::addr_t fire_addr;
    blimp_pkg::addr_t resp_addr;
    int               resp_wait;
    imem_req_rdy   = 1'b0;
    imem_resp_val  = 1'b0;
    imem_resp_data = '0;
    resp_wait      = 0;
    resp_addr      = '0;
    @(posedge clk);
    forever begin
      // Handshake sampled mid-cycle, acts at the next edge
      @(negedge clk);
      fire      = arst_n && imem_req_val && imem_req_rdy;
      fire_addr = imem_req_addr;
      @(posedge clk);
      #1;
      imem_resp_val = 1'b0;
      if (resp_wait > 0) begin
        resp_wait--;
        if (resp_wait == 0) begin
          imem_resp_val  = 1'b1;
          imem_resp_data = rom_word(resp_addr);
        end
      end
      if (fire) begin
        // First request at reset PC, then +4 each
        assert (fire_addr == exp_req_addr) else begin
          $display("MISMATCH @%0t: request address %h, expected %h",
                   $time, fire_addr, exp_req_addr);
          mismatches++;
        end
        exp_req_addr = exp_req_addr + 32'd4;
        resp_addr    = fire_addr;
        resp_wait    = 1 + ({$random(seed)} % 2);
      end
      imem_req_rdy = 1'($random(seed));
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Quiet outputs in reset and the first cycle after
  initial begin
    @(posedge clk);
    @(negedge clk);
    while (!arst_n) begin
      assert (!trace_val && !imem_req_val) else begin
        $display("MISMATCH @%0t: trace_val or imem_req_val high in reset", $time);
        mismatches++;
      end
      @(negedge clk);
    end
    assert (!trace_val && !imem_req_val) else begin
      $display("MISMATCH @%0t: trace_val or imem_req_val high after reset", $time);
      mismatches++;
    end
  end

  task automatic check_record(int unsigned idx);
    int unsigned exp_seq;
    // Tags count up in program order from zero and wrap
    exp_seq = idx % (1 << `BLIMP_SEQ_BITS);
    assert (trace_waddr == exp_waddr[idx] && trace_wdata == exp_wdata[idx]) else begin
      $display("MISMATCH @%0t: %s pc %h wrote x%0d=%h, expected x%0d=%h", $time,
               exp_is_mul[idx] ? "MUL" : "ALU", trace_pc, trace_waddr, trace_wdata,
               exp_waddr[idx], exp_wdata[idx]);
      mismatches++;
    end
    assert (trace_wen == (exp_waddr[idx] != '0)) else begin
      $display("MISMATCH @%0t: pc %h trace_wen %b", $time, trace_pc, trace_wen);
      mismatches++;
    end
    assert (trace_seq_num == exp_seq) else begin
      $display("MISMATCH @%0t: pc %h seq_num %0d, expected %0d", $time, trace_pc,
               trace_seq_num, exp_seq);
      mismatches++;
    end
    if (exp_is_mul[idx]) begin
      mul_checked++;
    end else begin
      alu_checked++;
    end
    if (traced[idx] == 0) begin
      traced_total++;
    end
    traced[idx]++;
  endtask

  // Trace monitor, completion order is free
  initial begin
    int unsigned idx;
    forever begin
      @(negedge clk);
      if (arst_n && trace_val === 1'b1) begin
        assert (!(trace_waddr == '0 && trace_wen)) else begin
          $display("MISMATCH @%0t: pc %h targets x0 with trace_wen high", $time, trace_pc);
          mismatches++;
        end
        if (trace_pc < `BLIMP_RESET_PC) begin
          $display("Trace record with pc %h below the reset PC at %0t", trace_pc, $time);
          failures++;
        end else begin
          idx = (trace_pc - `BLIMP_RESET_PC) >> 2;
          if (idx < PROG_LEN) begin
            check_record(idx);
          end
        end
      end
    end
  end

  task automatic print_summary();
    $display("Summary: %0d mismatches, %0d other errors, %0d ALU and %0d MUL records checked",
             mismatches, failures, alu_checked, mul_checked);
  endtask

  // --------------------
  // Run control
  // --------------------
  initial begin
    build_program();
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
    wait (traced_total == PROG_LEN);
    // Let stray duplicates show up
    repeat (DRAIN_CYCLES) @(posedge clk);
    for (int i = 0; i < PROG_LEN; i++) begin
      assert (traced[i] == 1) else begin
        $display("Program pc %h was committed %0d times instead of once",
                 `BLIMP_RESET_PC + 32'(i * 4), traced[i]);
        failures++;
      end
    end
    print_summary();
    if (mismatches + failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the program length
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d of %0d instructions committed",
             WATCHDOG_CYCLES, traced_total, PROG_LEN);
    failures++;
    print_summary();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
design/blimp_pkg.sv
design/blimp_intf.sv
design/fetch_unit.sv
design/decode_issue_unit.sv
design/alu_unit.sv
design/multiplier_unit.sv
design/writeback_commit_unit.sv
design/blimp_core.sv
bench/blimp_core_tb.sv

// ==== Bender.yml ====
package:
  name: blimp_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/blimp_pkg.sv
      - design/blimp_intf.sv
      - design/fetch_unit.sv
      - design/decode_issue_unit.sv
      - design/alu_unit.sv
      - design/multiplier_unit.sv
      - design/writeback_commit_unit.sv
      - design/blimp_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/blimp_core_tb.sv
